/* source/mist_config.svh */
// widths, download address size and OSD window for the MiST shell
// include wherever a width or OSD bound is needed
`ifndef MIST_CONFIG_SVH
`define MIST_CONFIG_SVH

// colour widths
`define MIST_CHAN_W 6
`define MIST_GAME_W 4

// ROM download address
`define MIST_ADDR_W 22

// pixel and line counters in the video selector
`define MIST_CNT_W 11

// OSD window in active pixels and lines, start inclusive, end exclusive
`define MIST_OSD_X0 4
`define MIST_OSD_X1 12
`define MIST_OSD_Y0 2
`define MIST_OSD_Y1 6

// added to the halved channel inside the window
`define MIST_OSD_TINT 6'd12

`endif

/* source/mist_spi_pkg.sv */
// command opcodes and receiver states of the SPI command port
// imported by the SPI slave only
package mist_spi_pkg;

   // first byte of every frame
   typedef enum logic [7:0] {
      // 4 payload bytes, LSB first
      CMD_JOY0     = 8'h02,
      CMD_JOY1     = 8'h03,
      CMD_STATUS   = 8'h1e,
      // no payload
      CMD_DL_START = 8'h53,
      CMD_DL_END   = 8'h55,
      // any number of ROM bytes follow
      CMD_DL_DATA  = 8'h54
   } spi_cmd_e;

   typedef enum logic [1:0] {
      IDLE,
      OPCODE,
      PAYLOAD,
      SKIP
   } spi_state_e;

endpackage

/* source/mist_video_pkg.sv */
// types and status bit positions shared by the video stages
// imported by the video selector, OSD channels, encoder and top
`include "mist_config.svh"

package mist_video_pkg;

   // one colour channel at output width
   typedef logic [`MIST_CHAN_W-1:0] chan_t;

   typedef enum logic {
      MODE_RGB,
      MODE_YPBPR
   } vid_mode_e;

   // positions inside status_o
   localparam int ST_SD_DISABLE = 1;
   localparam int ST_YPBPR      = 2;
   localparam int ST_OSD_EN     = 3;

endpackage

/* source/mist_pix_if.sv */
// one pixel with its syncs, active flag and OSD window flag
// driven by the video selector, read by the output encoder
`include "mist_config.svh"

interface mist_pix_if;

   logic [`MIST_CHAN_W-1:0] r;
   logic [`MIST_CHAN_W-1:0] g;
   logic [`MIST_CHAN_W-1:0] b;
   // syncs are active low here
   logic hs;
   logic vs;
   logic de;
   logic in_osd;

   modport src (
      output r, g, b, hs, vs, de, in_osd
   );

   modport sink (
      input r, g, b, hs, vs, de, in_osd
   );

endinterface

/* source/mist_spi_io.sv */
// SPI slave for the I/O controller, oversampled on clk_sys
// decodes frames into status, joystick words and ROM download bytes
`include "mist_config.svh"

module mist_spi_io import mist_spi_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_n_i,
   input  logic                    spi_sck_i,
   input  logic                    spi_ss_n_i,
   input  logic                    spi_di_i,
   output logic                    spi_do_o,
   output logic [31:0]             status_o,
   output logic [31:0]             joystick1_o,
   output logic [31:0]             joystick2_o,
   output logic [`MIST_ADDR_W-1:0] ioctl_addr_o,
   output logic [7:0]              ioctl_data_o,
   output logic                    ioctl_valid_o,
   input  logic                    ioctl_ready_i,
   output logic                    downloading_o,
   output logic                    ioctl_ovf_o
);

   logic [2:0]  sck_q;
   logic [1:0]  ss_q;
   logic [1:0]  di_q;
   logic        frame_on;
   logic        bit_rise;
   logic        byte_done;
   logic        load_dl;
   logic [2:0]  bit_cnt;
   logic [1:0]  byte_cnt;
   logic [7:0]  rx_sh;
   logic [7:0]  tx_sh;
   logic [7:0]  byte_new;
   logic [23:0] word_sh;
   logic [31:0] word_new;
   spi_state_e  state;
   spi_cmd_e    cmd;

   // pins through two flops, sck gets a third for edge detection
   assign frame_on  = ~ss_q[1];
   assign bit_rise  = frame_on & sck_q[1] & ~sck_q[2];
   assign byte_done = bit_rise & (bit_cnt == 3'd7);
   assign byte_new  = {rx_sh[6:0], di_q[1]};
   assign word_new  = {byte_new, word_sh};
   assign spi_do_o  = tx_sh[7];

   // a byte still waiting for ready means the new one is lost
   assign load_dl = byte_done && state == PAYLOAD && cmd == CMD_DL_DATA &&
                    !(ioctl_valid_o && !ioctl_ready_i);

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sck_q         <= '0;
         ss_q          <= '1;
         di_q          <= '0;
         state         <= IDLE;
         cmd           <= CMD_STATUS;
         bit_cnt       <= '0;
         byte_cnt      <= '0;
         tx_sh         <= '0;
         status_o      <= '0;
         joystick1_o   <= '0;
         joystick2_o   <= '0;
         ioctl_addr_o  <= '0;
         ioctl_valid_o <= 1'b0;
         downloading_o <= 1'b0;
         ioctl_ovf_o   <= 1'b0;
      end else begin
         sck_q <= {sck_q[1:0], spi_sck_i};
         ss_q  <= {ss_q[0], spi_ss_n_i};
         di_q  <= {di_q[0], spi_di_i};

         if (ioctl_valid_o && ioctl_ready_i) begin
            ioctl_valid_o <= 1'b0;
            ioctl_addr_o  <= ioctl_addr_o + 1'b1;
         end

         if (!frame_on) begin
            state   <= IDLE;
            bit_cnt <= '0;
         end else begin
            if (state == IDLE)
               state <= OPCODE;
            if (bit_rise) begin
               bit_cnt <= bit_cnt + 1'b1;
               tx_sh   <= {tx_sh[6:0], 1'b0};
            end
            if (byte_done) begin
               // echo of the byte just received
               tx_sh <= byte_new;
               case (state)
                  OPCODE: begin
                     cmd      <= spi_cmd_e'(byte_new);
                     byte_cnt <= '0;
                     case (spi_cmd_e'(byte_new))
                        CMD_STATUS, CMD_JOY0, CMD_JOY1, CMD_DL_DATA:
                           state <= PAYLOAD;
                        CMD_DL_START: begin
                           ioctl_addr_o  <= '0;
                           downloading_o <= 1'b1;
                           ioctl_ovf_o   <= 1'b0;
                           state         <= SKIP;
                        end
                        CMD_DL_END: begin
                           downloading_o <= 1'b0;
                           state         <= SKIP;
                        end
                        default: state <= SKIP;
                     endcase
                  end
                  PAYLOAD: begin
                     if (cmd == CMD_DL_DATA) begin
                        if (load_dl)
                           ioctl_valid_o <= 1'b1;
                        else
                           ioctl_ovf_o <= 1'b1;
                     end else if (byte_cnt == 2'd3) begin
                        // joystick 0 from the controller feeds joystick2_o
                        case (cmd)
                           CMD_STATUS: status_o    <= word_new;
                           CMD_JOY0:   joystick2_o <= word_new;
                           default:    joystick1_o <= word_new;
                        endcase
                        state <= SKIP;
                     end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                     end
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   // shift and payload data
   always_ff @(posedge clk_sys) begin
      if (bit_rise)
         rx_sh <= byte_new;
      if (byte_done)
         word_sh <= word_new[31:8];
      if (load_dl)
         ioctl_data_o <= byte_new;
   end

endmodule

/* source/mist_video_select.sv */
// picks game or scandoubled VGA video and registers it as one pixel
// also tracks active pixel and line counts to flag the OSD window
`include "mist_config.svh"

module mist_video_select import mist_video_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_n_i,
   input  logic [`MIST_GAME_W-1:0] game_r_i,
   input  logic [`MIST_GAME_W-1:0] game_g_i,
   input  logic [`MIST_GAME_W-1:0] game_b_i,
   input  logic                    lhbl_i,
   input  logic                    lvbl_i,
   input  logic                    hs_i,
   input  logic                    vs_i,
   input  chan_t                   vga_r_i,
   input  chan_t                   vga_g_i,
   input  chan_t                   vga_b_i,
   input  logic                    vga_hs_i,
   input  logic                    vga_vs_i,
   input  logic                    sd_disable_i,
   mist_pix_if.src                 pix
);

   chan_t                  r_nxt;
   chan_t                  g_nxt;
   chan_t                  b_nxt;
   logic                   hs_nxt;
   logic                   vs_nxt;
   logic                   de_nxt;
   logic                   osd_nxt;
   logic [`MIST_CNT_W-1:0] x_cnt;
   logic [`MIST_CNT_W-1:0] y_cnt;

   // top bits repeated into the low end
   function automatic chan_t widen(input logic [`MIST_GAME_W-1:0] c);
      return {c, c[`MIST_GAME_W-1 -: (`MIST_CHAN_W - `MIST_GAME_W)]};
   endfunction

   // game syncs are active high, VGA ones already active low
   assign r_nxt  = sd_disable_i ? widen(game_r_i) : vga_r_i;
   assign g_nxt  = sd_disable_i ? widen(game_g_i) : vga_g_i;
   assign b_nxt  = sd_disable_i ? widen(game_b_i) : vga_b_i;
   assign hs_nxt = sd_disable_i ? ~hs_i : vga_hs_i;
   assign vs_nxt = sd_disable_i ? ~vs_i : vga_vs_i;
   assign de_nxt = lhbl_i & lvbl_i;

   assign osd_nxt = de_nxt &&
                    x_cnt >= `MIST_OSD_X0 && x_cnt < `MIST_OSD_X1 &&
                    y_cnt >= `MIST_OSD_Y0 && y_cnt < `MIST_OSD_Y1;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         x_cnt      <= '0;
         y_cnt      <= '0;
         pix.r      <= '0;
         pix.g      <= '0;
         pix.b      <= '0;
         pix.hs     <= 1'b0;
         pix.vs     <= 1'b0;
         pix.de     <= 1'b0;
         pix.in_osd <= 1'b0;
      end else begin
         // x is the index of the incoming pixel within its line
         x_cnt <= de_nxt ? x_cnt + 1'b1 : '0;
         // next line on the falling edge of de, restart in vsync
         if (!vs_nxt)
            y_cnt <= '0;
         else if (pix.de && !de_nxt)
            y_cnt <= y_cnt + 1'b1;
         pix.r      <= r_nxt;
         pix.g      <= g_nxt;
         pix.b      <= b_nxt;
         pix.hs     <= hs_nxt;
         pix.vs     <= vs_nxt;
         pix.de     <= de_nxt;
         pix.in_osd <= osd_nxt;
      end
   end

endmodule

/* source/mist_osd_chan.sv */
// one colour channel of the OSD overlay, one register stage
// inside the window the channel is dimmed to half and tinted
`include "mist_config.svh"

module mist_osd_chan import mist_video_pkg::*; (
   input  logic  clk_sys,
   input  logic  rst_n_i,
   input  chan_t chan_i,
   input  logic  in_osd_i,
   input  logic  osd_en_i,
   output chan_t chan_o
);

   // one extra bit catches the carry of the tint
   logic [`MIST_CHAN_W:0] blend;

   assign blend = {2'b00, chan_i[`MIST_CHAN_W-1:1]} + `MIST_OSD_TINT;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         chan_o <= '0;
      end else if (in_osd_i && osd_en_i) begin
         // saturate at full scale
         chan_o <= blend[`MIST_CHAN_W] ? '1 : blend[`MIST_CHAN_W-1:0];
      end else begin
         chan_o <= chan_i;
      end
   end

endmodule

/* source/mist_video_out.sv */
// final encoder, RGB passthrough or YPbPr, and the output syncs
// composite sync on HS with VS high for 15kHz or YPbPr displays
`include "mist_config.svh"

module mist_video_out import mist_video_pkg::*; (
   input  logic     clk_sys,
   input  logic     rst_n_i,
   input  logic     ypbpr_i,
   input  logic     sd_disable_i,
   mist_pix_if.sink pix,
   output chan_t    video_r_o,
   output chan_t    video_g_o,
   output chan_t    video_b_o,
   output logic     video_hs_o,
   output logic     video_vs_o
);

   localparam int CHAN_MID = 1 << (`MIST_CHAN_W - 1);
   localparam int CHAN_MAX = (1 << `MIST_CHAN_W) - 1;

   vid_mode_e mode;
   logic      csync_mode;
   logic      hs_d;
   logic      vs_d;
   int        y_sum;
   int        pb_val;
   int        pr_val;
   chan_t     y_c;
   chan_t     pb_c;
   chan_t     pr_c;

   function automatic chan_t clamp(input int v);
      if (v < 0)
         return '0;
      if (v > CHAN_MAX)
         return chan_t'(CHAN_MAX);
      return chan_t'(v);
   endfunction

   assign mode       = ypbpr_i ? MODE_YPBPR : MODE_RGB;
   assign csync_mode = sd_disable_i | ypbpr_i;

   // halving is an arithmetic shift, so negative differences round down
   always_comb begin
      y_sum  = 2 * int'(pix.r) + 5 * int'(pix.g) + int'(pix.b);
      y_c    = chan_t'(y_sum >>> 3);
      pb_val = CHAN_MID + ((int'(pix.b) - int'(y_c)) >>> 1);
      pr_val = CHAN_MID + ((int'(pix.r) - int'(y_c)) >>> 1);
      pb_c   = clamp(pb_val);
      pr_c   = clamp(pr_val);
   end

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hs_d       <= 1'b0;
         vs_d       <= 1'b0;
         video_r_o  <= '0;
         video_g_o  <= '0;
         video_b_o  <= '0;
         video_hs_o <= 1'b0;
         video_vs_o <= 1'b0;
      end else begin
         // syncs skip the OSD stage so they wait one extra cycle here
         hs_d <= pix.hs;
         vs_d <= pix.vs;
         case (mode)
            MODE_YPBPR: begin
               video_r_o <= pr_c;
               video_g_o <= y_c;
               video_b_o <= pb_c;
            end
            default: begin
               video_r_o <= pix.r;
               video_g_o <= pix.g;
               video_b_o <= pix.b;
            end
         endcase
         video_hs_o <= csync_mode ? ~(hs_d ^ vs_d) : hs_d;
         video_vs_o <= csync_mode | vs_d;
      end
   end

endmodule

/* source/mist_base.sv */
// MiST platform shell between a game core and the board
// SPI command port plus video select, OSD overlay and output encoder
`include "mist_config.svh"

module mist_base import mist_video_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_n_i,
   // game video
   input  logic [`MIST_GAME_W-1:0] game_r_i,
   input  logic [`MIST_GAME_W-1:0] game_g_i,
   input  logic [`MIST_GAME_W-1:0] game_b_i,
   input  logic                    lhbl_i,
   input  logic                    lvbl_i,
   input  logic                    hs_i,
   input  logic                    vs_i,
   // scandoubled video
   input  chan_t                   vga_r_i,
   input  chan_t                   vga_g_i,
   input  chan_t                   vga_b_i,
   input  logic                    vga_hs_i,
   input  logic                    vga_vs_i,
   // I/O controller
   input  logic                    spi_sck_i,
   input  logic                    spi_ss_n_i,
   input  logic                    spi_di_i,
   output logic                    spi_do_o,
   output logic [31:0]             status_o,
   output logic [31:0]             joystick1_o,
   output logic [31:0]             joystick2_o,
   // ROM download
   output logic [`MIST_ADDR_W-1:0] ioctl_addr_o,
   output logic [7:0]              ioctl_data_o,
   output logic                    ioctl_valid_o,
   input  logic                    ioctl_ready_i,
   output logic                    downloading_o,
   output logic                    ioctl_ovf_o,
   // board video
   output chan_t                   video_r_o,
   output chan_t                   video_g_o,
   output chan_t                   video_b_o,
   output logic                    video_hs_o,
   output logic                    video_vs_o,
   output logic                    osd_shown_o
);

   mist_pix_if pix_sel ();
   mist_pix_if pix_osd ();

   chan_t sel_c [3];
   chan_t osd_c [3];

   assign osd_shown_o = status_o[ST_OSD_EN];

   mist_spi_io u_spi (
      .clk_sys       ( clk_sys       ),
      .rst_n_i       ( rst_n_i       ),
      .spi_sck_i     ( spi_sck_i     ),
      .spi_ss_n_i    ( spi_ss_n_i    ),
      .spi_di_i      ( spi_di_i      ),
      .spi_do_o      ( spi_do_o      ),
      .status_o      ( status_o      ),
      .joystick1_o   ( joystick1_o   ),
      .joystick2_o   ( joystick2_o   ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_valid_o ( ioctl_valid_o ),
      .ioctl_ready_i ( ioctl_ready_i ),
      .downloading_o ( downloading_o ),
      .ioctl_ovf_o   ( ioctl_ovf_o   )
   );

   mist_video_select u_select (
      .clk_sys      ( clk_sys                  ),
      .rst_n_i      ( rst_n_i                  ),
      .game_r_i     ( game_r_i                 ),
      .game_g_i     ( game_g_i                 ),
      .game_b_i     ( game_b_i                 ),
      .lhbl_i       ( lhbl_i                   ),
      .lvbl_i       ( lvbl_i                   ),
      .hs_i         ( hs_i                     ),
      .vs_i         ( vs_i                     ),
      .vga_r_i      ( vga_r_i                  ),
      .vga_g_i      ( vga_g_i                  ),
      .vga_b_i      ( vga_b_i                  ),
      .vga_hs_i     ( vga_hs_i                 ),
      .vga_vs_i     ( vga_vs_i                 ),
      .sd_disable_i ( status_o[ST_SD_DISABLE]  ),
      .pix          ( pix_sel                  )
   );

   // channels in r, g, b order
   assign sel_c[0] = pix_sel.r;
   assign sel_c[1] = pix_sel.g;
   assign sel_c[2] = pix_sel.b;

   for (genvar i = 0; i < 3; i++) begin : g_osd
      mist_osd_chan u_chan (
         .clk_sys  ( clk_sys              ),
         .rst_n_i  ( rst_n_i              ),
         .chan_i   ( sel_c[i]             ),
         .in_osd_i ( pix_sel.in_osd       ),
         .osd_en_i ( status_o[ST_OSD_EN]  ),
         .chan_o   ( osd_c[i]             )
      );
   end

   // overlaid colour, flags straight from the selector
   assign pix_osd.r      = osd_c[0];
   assign pix_osd.g      = osd_c[1];
   assign pix_osd.b      = osd_c[2];
   assign pix_osd.hs     = pix_sel.hs;
   assign pix_osd.vs     = pix_sel.vs;
   assign pix_osd.de     = pix_sel.de;
   assign pix_osd.in_osd = pix_sel.in_osd;

   mist_video_out u_out (
      .clk_sys      ( clk_sys                  ),
      .rst_n_i      ( rst_n_i                  ),
      .ypbpr_i      ( status_o[ST_YPBPR]       ),
      .sd_disable_i ( status_o[ST_SD_DISABLE]  ),
      .pix          ( pix_osd                  ),
      .video_r_o    ( video_r_o                ),
      .video_g_o    ( video_g_o                ),
      .video_b_o    ( video_b_o                ),
      .video_hs_o   ( video_hs_o               ),
      .video_vs_o   ( video_vs_o               )
   );

endmodule

/* bench/mist_base_tb.sv */
// testbench for the MiST shell: SPI commands, ROM download and the video path
// every step comes from bench/mist_stimulus.txt, run from the project root
`include "mist_config.svh"

module mist_base_tb import mist_spi_pkg::*, mist_video_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   // test raster, both sources share the blanking
   localparam int H_ACT    = 16;
   localparam int H_TOT    = 24;
   localparam int V_TOT    = 10;
   localparam int FRAME    = H_TOT * V_TOT;
   localparam int SPI_BYTE = 64;

   logic                    clk_sys;
   logic                    rst_n_i;
   logic [`MIST_GAME_W-1:0] game_r_i;
   logic [`MIST_GAME_W-1:0] game_g_i;
   logic [`MIST_GAME_W-1:0] game_b_i;
   logic                    lhbl_i;
   logic                    lvbl_i;
   logic                    hs_i;
   logic                    vs_i;
   logic [`MIST_CHAN_W-1:0] vga_r_i;
   logic [`MIST_CHAN_W-1:0] vga_g_i;
   logic [`MIST_CHAN_W-1:0] vga_b_i;
   logic                    vga_hs_i;
   logic                    vga_vs_i;
   logic                    spi_sck_i;
   logic                    spi_ss_n_i;
   logic                    spi_di_i;
   logic                    spi_do_o;
   logic [31:0]             status_o;
   logic [31:0]             joystick1_o;
   logic [31:0]             joystick2_o;
   logic [`MIST_ADDR_W-1:0] ioctl_addr_o;
   logic [7:0]              ioctl_data_o;
   logic                    ioctl_valid_o;
   logic                    ioctl_ready_i;
   logic                    downloading_o;
   logic                    ioctl_ovf_o;
   logic [`MIST_CHAN_W-1:0] video_r_o;
   logic [`MIST_CHAN_W-1:0] video_g_o;
   logic [`MIST_CHAN_W-1:0] video_b_o;
   logic                    video_hs_o;
   logic                    video_vs_o;
   logic                    osd_shown_o;

   logic                    hold_ready;
   logic [7:0]              last_sent;
   int                      cycles;
   int                      limit;
   logic [`MIST_ADDR_W-1:0] got_addr [$];
   logic [7:0]              got_data [$];
   string                   steps [$];

   mist_base DUT (.*);

   initial begin
      clk_sys = 1'b0;
      forever #20 clk_sys = ~clk_sys;
   end

   task automatic fail(input string msg);
      $display("TEST FAIL");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, got);
         fail($sformatf("%s has a wrong value", name));
      end
   endtask

   always @(posedge clk_sys) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit)
         fail($sformatf("timeout, the run did not end within %0d cycles", limit));
   end

   // random stalls unless a step holds ready low
   always @(posedge clk_sys)
      ioctl_ready_i <= hold_ready ? 1'b0 : ($urandom % 4 != 0);

   // every accepted ROM byte
   always @(posedge clk_sys) begin
      if (ioctl_valid_o && ioctl_ready_i) begin
         got_addr.push_back(ioctl_addr_o);
         got_data.push_back(ioctl_data_o);
      end
   end

   task automatic tick(input int n);
      repeat (n) @(posedge clk_sys);
   endtask

   // sck period of 8 clocks, data valid before the rising edge
   // spi_do_o shifts out the previous byte, sampled late in the low phase
   task automatic spi_byte(input logic [7:0] b);
      for (int i = 7; i >= 0; i--) begin
         spi_di_i  <= b[i];
         spi_sck_i <= 1'b0;
         tick(3);
         @(negedge clk_sys);
         check_value("spi_do_o", spi_do_o, last_sent[i]);
         @(posedge clk_sys);
         spi_sck_i <= 1'b1;
         tick(4);
      end
      last_sent = b;
   endtask

   // byte 0 goes out first
   task automatic spi_frame(input logic [39:0] data, input int n);
      spi_ss_n_i <= 1'b0;
      tick(4);
      for (int k = 0; k < n; k++)
         spi_byte(data[8*k +: 8]);
      spi_sck_i <= 1'b0;
      tick(4);
      spi_ss_n_i <= 1'b1;
      tick(8);
   endtask

   function automatic bit hsync_at(input int i);
      return (i % H_TOT) >= 18 && (i % H_TOT) < 21;
   endfunction

   function automatic bit vsync_at(input int i);
      return (i % FRAME) < H_TOT;
   endfunction

   // first two lines of a frame are vertical blanking
   function automatic bit in_window(input int i);
      int x;
      int y;
      x = i % H_TOT;
      y = (i % FRAME) / H_TOT - 2;
      return x < H_ACT && y >= 0 && x >= `MIST_OSD_X0 && x < `MIST_OSD_X1 &&
             y >= `MIST_OSD_Y0 && y < `MIST_OSD_Y1;
   endfunction

   function automatic int step_cycles(input string s);
      int hold;
      int nsent;
      if (s.substr(0, 2) == "VID")
         return FRAME + 4;
      if (s.substr(0, 2) == "ROM") begin
         void'($sscanf(s, "ROM %d %d", hold, nsent));
         return (nsent + 3) * SPI_BYTE + 64;
      end
      return 5 * SPI_BYTE + 16;
   endfunction

   task automatic send_command(input string s);
      logic [7:0]  op;
      logic [31:0] word;
      int          n;
      n = $sscanf(s, "SPI %h %h", op, word);
      assert (n == 2) else fail({"malformed stimulus line: ", s});
      spi_frame({word, op}, 5);
      case (spi_cmd_e'(op))
         CMD_STATUS: begin
            check_value("status_o", status_o, word);
            check_value("osd_shown_o", osd_shown_o, word[ST_OSD_EN]);
         end
         CMD_JOY0: check_value("joystick2_o", joystick2_o, word);
         default:  check_value("joystick1_o", joystick1_o, word);
      endcase
   endtask

   task automatic download_rom(input string s);
      int          hold;
      int          nsent;
      int          nexp;
      int          ovf;
      logic [7:0]  b [4];
      logic [31:0] data;
      int          n;
      n = $sscanf(s, "ROM %d %d %d %d %h %h %h %h", hold, nsent, nexp, ovf,
                  b[0], b[1], b[2], b[3]);
      assert (n == 8) else fail({"malformed stimulus line: ", s});
      data = {b[3], b[2], b[1], b[0]};
      got_addr.delete();
      got_data.delete();
      spi_frame({32'h0, CMD_DL_START}, 1);
      check_value("downloading_o", downloading_o, 1);
      hold_ready <= (hold != 0);
      spi_frame({data, CMD_DL_DATA}, nsent + 1);
      hold_ready <= 1'b0;
      spi_frame({32'h0, CMD_DL_END}, 1);
      while (ioctl_valid_o)
         tick(1);
      check_value("downloading_o", downloading_o, 0);
      check_value("ioctl_ovf_o", ioctl_ovf_o, ovf);
      assert (got_data.size() == nexp) else
         fail($sformatf("%0d ROM bytes delivered, %0d expected", got_data.size(), nexp));
      for (int i = 0; i < nexp; i++) begin
         check_value("ioctl_addr_o", got_addr[i], i);
         check_value("ioctl_data_o", got_data[i], data[8*i +: 8]);
      end
   endtask

   // one frame, output of pixel i-3 sampled on the falling edge
   task automatic play_frame(input string s);
      logic [`MIST_GAME_W-1:0] gc [3];
      logic [`MIST_CHAN_W-1:0] vc [3];
      logic [`MIST_CHAN_W-1:0] oc [3];
      logic [`MIST_CHAN_W-1:0] ic [3];
      int                      csync;
      int                      n;
      int                      j;
      bit                      w;
      n = $sscanf(s, "VID %h %h %h %h %h %h %h %h %h %h %h %h %d", gc[0], gc[1], gc[2],
                  vc[0], vc[1], vc[2], oc[0], oc[1], oc[2], ic[0], ic[1], ic[2], csync);
      assert (n == 13) else fail({"malformed stimulus line: ", s});
      game_r_i <= gc[0];
      game_g_i <= gc[1];
      game_b_i <= gc[2];
      vga_r_i  <= vc[0];
      vga_g_i  <= vc[1];
      vga_b_i  <= vc[2];
      for (int i = 0; i < FRAME + 3; i++) begin
         @(posedge clk_sys);
         lhbl_i   <= (i % H_TOT) < H_ACT;
         lvbl_i   <= (i % FRAME) >= 2 * H_TOT;
         hs_i     <= hsync_at(i);
         vs_i     <= vsync_at(i);
         vga_hs_i <= !hsync_at(i);
         vga_vs_i <= !vsync_at(i);
         @(negedge clk_sys);
         if (i >= 3) begin
            j = i - 3;
            w = in_window(j);
            check_value("video_r_o", video_r_o, w ? ic[0] : oc[0]);
            check_value("video_g_o", video_g_o, w ? ic[1] : oc[1]);
            check_value("video_b_o", video_b_o, w ? ic[2] : oc[2]);
            check_value("video_hs_o", video_hs_o,
                        csync ? !(hsync_at(j) ^ vsync_at(j)) : !hsync_at(j));
            check_value("video_vs_o", video_vs_o, csync ? 1 : !vsync_at(j));
         end
      end
      @(posedge clk_sys);
   endtask

   initial begin
      int    fd;
      string s;
      int    budget;
      void'($urandom(32'hc7d1));
      rst_n_i       = 1'b0;
      {game_r_i, game_g_i, game_b_i} = '0;
      {vga_r_i, vga_g_i, vga_b_i}    = '0;
      {lhbl_i, lvbl_i, hs_i, vs_i}   = '0;
      vga_hs_i      = 1'b1;
      vga_vs_i      = 1'b1;
      spi_sck_i     = 1'b0;
      spi_ss_n_i    = 1'b1;
      spi_di_i      = 1'b0;
      ioctl_ready_i = 1'b0;
      hold_ready    = 1'b0;
      last_sent     = '0;
      cycles        = 0;
      limit         = 0;
      fd = $fopen("bench/mist_stimulus.txt", "r");
      assert (fd != 0) else fail("cannot open bench/mist_stimulus.txt");
      while ($fgets(s, fd) > 0) begin
         if (s.len() > 3 && s.getc(0) != "#")
            steps.push_back(s);
      end
      $fclose(fd);
      budget = 16;
      foreach (steps[k])
         budget += step_cycles(steps[k]);
      limit = 2 * budget;

      tick(4);
      check_value("ioctl_valid_o", ioctl_valid_o, 0);
      check_value("downloading_o", downloading_o, 0);
      check_value("ioctl_ovf_o", ioctl_ovf_o, 0);
      check_value("status_o", status_o, 0);
      check_value("joystick1_o", joystick1_o, 0);
      check_value("joystick2_o", joystick2_o, 0);
      check_value("video_r_o", video_r_o, 0);
      check_value("video_g_o", video_g_o, 0);
      check_value("video_b_o", video_b_o, 0);
      check_value("video_hs_o", video_hs_o, 0);
      check_value("video_vs_o", video_vs_o, 0);
      check_value("osd_shown_o", osd_shown_o, 0);
      rst_n_i <= 1'b1;
      tick(2);

      foreach (steps[k]) begin
         if (steps[k].substr(0, 2) == "SPI")
            send_command(steps[k]);
         else if (steps[k].substr(0, 2) == "ROM")
            download_rom(steps[k]);
         else if (steps[k].substr(0, 2) == "VID")
            play_frame(steps[k]);
         else
            fail({"unknown tag in stimulus line: ", steps[k]});
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

/* bench/mist_stimulus.txt */
# SPI op word : command frame, word sent LSB first and read back on its output
# ROM hold sent delivered ovf b0 b1 b2 b3 : download, hold 1 keeps ready low over the data
# VID game_rgb vga_rgb out_rgb osd_rgb csync : one frame, osd_rgb inside the OSD window
SPI 1e 00000000
SPI 02 a5c3f00f
SPI 03 12345678
SPI 1e 80000001
ROM 0 4 4 0 a5 3c 7e 01
ROM 1 2 1 1 c3 5a 00 00
ROM 0 3 3 0 11 22 33 00
SPI 1e 00000000
VID a 5 f 2a 15 3f 2a 15 3f 2a 15 3f 0
SPI 1e 00000002
VID 9 3 e 01 02 03 26 0c 3b 26 0c 3b 1
SPI 1e 0000000a
VID 9 3 e 01 02 03 26 0c 3b 1f 12 29 1
SPI 1e 00000008
VID 0 0 0 3e 30 04 3e 30 04 2b 24 0e 0
SPI 1e 00000004
VID 0 0 0 30 20 10 27 22 17 27 22 17 1
SPI 1e 0000000c
VID 0 0 0 3f 3f 3f 20 3f 20 20 2b 20 1

/* vlog.f */
+incdir+source
source/mist_spi_pkg.sv
source/mist_video_pkg.sv
source/mist_pix_if.sv
source/mist_spi_io.sv
source/mist_video_select.sv
source/mist_osd_chan.sv
source/mist_video_out.sv
source/mist_base.sv
bench/mist_base_tb.sv

/* run.sh */
#!/bin/sh
# build and run the MiST shell testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module mist_base_tb -Mdir obj_dir
./obj_dir/Vmist_base_tb
